/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_ecc_mem
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
ecc_pkg.sv
ecc_encoder.sv
ecc_checker.sv
ecc_storage.sv
ecc_err_counter.sv
ecc_mem_top.sv
ecc_assertions.sv
ecc_monitor.sv
tb_ecc_mem.sv

/* ecc_assertions.sv */
`timescale 1ns/1ps

module ecc_assertions import ecc_pkg::*; (
    input logic       clk,
    input logic       arst_n,
    input logic       rd_valid,
    input logic       rd_bypass,
    input logic       cnt_clr,
    input rd_result_t rd_result,
    input err_cnt_t   sbit_cnt,
    input err_cnt_t   dbit_cnt
);

    flags_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        rd_valid |-> !(rd_result.sbit_err && rd_result.dbit_err))
        else $error("sbit_err and dbit_err high together");

    // Bypass reads report no errors.
    bypass_no_flags: assert property (@(posedge clk) disable iff (!arst_n)
        (rd_valid && rd_bypass) |-> (!rd_result.sbit_err && !rd_result.dbit_err))
        else $error("error flag raised on a bypass read");

    sbit_cnt_no_drop: assert property (@(posedge clk) disable iff (!arst_n)
        !cnt_clr |=> (sbit_cnt >= $past(sbit_cnt)))
        else $error("sbit_cnt decreased without a clear");

    dbit_cnt_no_drop: assert property (@(posedge clk) disable iff (!arst_n)
        !cnt_clr |=> (dbit_cnt >= $past(dbit_cnt)))
        else $error("dbit_cnt decreased without a clear");

endmodule

// Watches the checker outputs and the counter instance through the top level.
bind ecc_mem_top ecc_assertions u_assert (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_valid  (rd_valid),
    .rd_bypass (rd_bypass),
    .cnt_clr   (cnt_clr),
    .rd_result (rd_result),
    .sbit_cnt  (sbit_cnt),
    .dbit_cnt  (dbit_cnt)
);

/* ecc_checker.sv */
`timescale 1ns/1ps

module ecc_checker import ecc_pkg::*; (
    input  codeword_t  word,
    input  logic       bypass,
    output rd_result_t result
);

    parity_t   calc_parity;
    syndrome_t syndrome;
    data_t     mask;
    logic      sbit;
    logic      dbit;

    ecc_encoder u_enc (
        .data   (word.data),
        .parity (calc_parity)
    );

    assign syndrome = word.parity ^ calc_parity;

    // Map the syndrome to a data column, a check bit or an uncorrectable pattern.
    always_comb begin
        mask = '0;
        dbit = 1'b0;
        case (syndrome)
            6'b000000: mask = '0;
            6'b100011: mask[0]  = 1'b1;
            6'b100101: mask[1]  = 1'b1;
            6'b100110: mask[2]  = 1'b1;
            6'b000111: mask[3]  = 1'b1;
            6'b101001: mask[4]  = 1'b1;
            6'b101010: mask[5]  = 1'b1;
            6'b001011: mask[6]  = 1'b1;
            6'b101100: mask[7]  = 1'b1;
            6'b001101: mask[8]  = 1'b1;
            6'b001110: mask[9]  = 1'b1;
            6'b101111: mask[10] = 1'b1;
            6'b110001: mask[11] = 1'b1;
            6'b110010: mask[12] = 1'b1;
            6'b010011: mask[13] = 1'b1;
            6'b110100: mask[14] = 1'b1;
            6'b010101: mask[15] = 1'b1;
            6'b010110: mask[16] = 1'b1;
            6'b110111: mask[17] = 1'b1;
            6'b111000: mask[18] = 1'b1;
            6'b011001: mask[19] = 1'b1;
            6'b011010: mask[20] = 1'b1;
            6'b111011: mask[21] = 1'b1;
            // Check-bit errors leave the data good.
            6'b100000,
            6'b010000,
            6'b001000,
            6'b000100,
            6'b000010,
            6'b000001: mask = '0;
            default: begin
                mask = '0;
                dbit = 1'b1;
            end
        endcase
    end

    // A corrected data column or a lone check-bit syndrome is a single error.
    assign sbit = (mask != '0) || ($countones(syndrome) == 1);

    // Bypass hands back the raw word with no flags.
    always_comb begin
        if (bypass) begin
            result.data     = word.data;
            result.sbit_err = 1'b0;
            result.dbit_err = 1'b0;
        end else begin
            result.data     = word.data ^ mask;
            result.sbit_err = sbit;
            result.dbit_err = dbit;
        end
    end

endmodule

/* ecc_encoder.sv */
`timescale 1ns/1ps

module ecc_encoder import ecc_pkg::*; (
    input  data_t   data,
    output parity_t parity
);

    // Each check bit covers a fixed subset of the data bits.
    always_comb begin
        parity[0] = data[0]  ^ data[1]  ^ data[3]  ^ data[4]  ^ data[6]  ^
                    data[8]  ^ data[10] ^ data[11] ^ data[13] ^ data[15] ^
                    data[17] ^ data[19] ^ data[21];

        parity[1] = data[0]  ^ data[2]  ^ data[3]  ^ data[5]  ^ data[6]  ^
                    data[9]  ^ data[10] ^ data[12] ^ data[13] ^ data[16] ^
                    data[17] ^ data[20] ^ data[21];

        parity[2] = data[1]  ^ data[2]  ^ data[3]  ^ data[7]  ^ data[8]  ^
                    data[9]  ^ data[10] ^ data[14] ^ data[15] ^ data[16] ^
                    data[17];

        parity[3] = data[4]  ^ data[5]  ^ data[6]  ^ data[7]  ^ data[8]  ^
                    data[9]  ^ data[10] ^ data[18] ^ data[19] ^ data[20] ^
                    data[21];

        parity[4] = data[11] ^ data[12] ^ data[13] ^ data[14] ^ data[15] ^
                    data[16] ^ data[17] ^ data[18] ^ data[19] ^ data[20] ^
                    data[21];

        // Overall-style bit, makes every data column odd weight.
        parity[5] = data[0]  ^ data[1]  ^ data[2]  ^ data[4]  ^ data[5]  ^
                    data[7]  ^ data[10] ^ data[11] ^ data[12] ^ data[14] ^
                    data[17] ^ data[18] ^ data[21];
    end

endmodule

/* ecc_err_counter.sv */
`timescale 1ns/1ps

module ecc_err_counter import ecc_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     valid,
    input  logic     sbit_err,
    input  logic     dbit_err,
    input  logic     clr,
    output err_cnt_t sbit_cnt,
    output err_cnt_t dbit_cnt
);

    // Holds at all ones instead of wrapping.
    function automatic err_cnt_t sat_inc(input err_cnt_t cnt);
        if (cnt == '1) begin
            return cnt;
        end
        return cnt + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sbit_cnt <= '0;
            dbit_cnt <= '0;
        end else if (clr) begin
            sbit_cnt <= '0;
            dbit_cnt <= '0;
        end else if (valid) begin
            if (sbit_err) begin
                sbit_cnt <= sat_inc(sbit_cnt);
            end
            if (dbit_err) begin
                dbit_cnt <= sat_inc(dbit_cnt);
            end
        end
    end

endmodule

/* ecc_mem_top.sv */
`timescale 1ns/1ps

module ecc_mem_top import ecc_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       wr_en,
    input  addr_t      wr_addr,
    input  data_t      wr_data,
    input  codeword_t  wr_flip,
    input  logic       rd_en,
    input  addr_t      rd_addr,
    input  logic       bypass,
    input  logic       cnt_clr,
    output logic       rd_valid,
    output rd_result_t rd_result,
    output err_cnt_t   sbit_cnt,
    output err_cnt_t   dbit_cnt
);

    parity_t   wr_parity;
    codeword_t wr_word;
    codeword_t rd_word;
    logic      rd_bypass;

    ecc_encoder u_wr_enc (
        .data   (wr_data),
        .parity (wr_parity)
    );

    assign wr_word = '{parity: wr_parity, data: wr_data};

    ecc_storage u_storage (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_word   (wr_word),
        .wr_flip   (wr_flip),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .bypass    (bypass),
        .rd_valid  (rd_valid),
        .rd_bypass (rd_bypass),
        .rd_word   (rd_word)
    );

    ecc_checker u_checker (
        .word   (rd_word),
        .bypass (rd_bypass),
        .result (rd_result)
    );

    // Counts flags from valid result cycles only.
    ecc_err_counter u_err_cnt (
        .clk      (clk),
        .arst_n   (arst_n),
        .valid    (rd_valid),
        .sbit_err (rd_result.sbit_err),
        .dbit_err (rd_result.dbit_err),
        .clr      (cnt_clr),
        .sbit_cnt (sbit_cnt),
        .dbit_cnt (dbit_cnt)
    );

endmodule

/* ecc_monitor.sv */
`timescale 1ns/1ps

module ecc_monitor import ecc_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       wr_en,
    input  addr_t      wr_addr,
    input  data_t      wr_data,
    input  codeword_t  wr_flip,
    input  logic       rd_en,
    input  addr_t      rd_addr,
    input  logic       bypass,
    input  logic       cnt_clr,
    input  logic       rd_valid,
    input  rd_result_t rd_result,
    input  err_cnt_t   sbit_cnt,
    input  err_cnt_t   dbit_cnt,
    output int         error_count,
    output int         read_count
);

    // Clean data and the fault pattern planted at each address.
    data_t      shadow_data [MEM_DEPTH];
    codeword_t  shadow_flip [MEM_DEPTH];
    logic       exp_valid;
    rd_result_t exp_result;
    err_cnt_t   exp_sbit_cnt;
    err_cnt_t   exp_dbit_cnt;
    int         errors = 0;
    int         reads = 0;

    assign error_count = errors;
    assign read_count  = reads;

    // SECDED outcome depends only on how many stored bits were flipped.
    function automatic rd_result_t expected_result(input data_t clean, input codeword_t flip,
                                                   input logic byp);
        rd_result_t res;
        int         flips;
        flips        = $countones(flip);
        res.data     = clean;
        res.sbit_err = 1'b0;
        res.dbit_err = 1'b0;
        if (byp) begin
            res.data = clean ^ flip.data;
        end else if (flips == 1) begin
            res.sbit_err = 1'b1;
        end else if (flips == 2) begin
            res.dbit_err = 1'b1;
        end
        return res;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        if (wr_en) begin
            shadow_data[wr_addr] <= wr_data;
            shadow_flip[wr_addr] <= wr_flip;
        end
    end

    // Read-first, so the lookup sees the shadow before this edge's write.
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_valid    <= 1'b0;
            exp_sbit_cnt <= '0;
            exp_dbit_cnt <= '0;
        end else begin
            exp_valid <= rd_en;
            if (rd_en) begin
                exp_result <= expected_result(shadow_data[rd_addr], shadow_flip[rd_addr],
                                              bypass);
            end
            if (cnt_clr) begin
                exp_sbit_cnt <= '0;
                exp_dbit_cnt <= '0;
            end else if (exp_valid) begin
                if (exp_result.sbit_err && exp_sbit_cnt != 8'hff) begin
                    exp_sbit_cnt <= exp_sbit_cnt + 8'd1;
                end
                if (exp_result.dbit_err && exp_dbit_cnt != 8'hff) begin
                    exp_dbit_cnt <= exp_dbit_cnt + 8'd1;
                end
            end
        end
    end

    // Outputs are settled mid-cycle.
    always @(negedge clk) begin
        if (arst_n) begin
            if (rd_valid !== exp_valid) begin
                errors++;
                if (exp_valid) begin
                    $display("rd_valid missing at %0t after a read request", $time);
                end else begin
                    $display("unexpected rd_valid at %0t without a read request", $time);
                end
            end else if (exp_valid) begin
                reads++;
                // Uncorrectable words carry no meaningful data.
                if (!exp_result.dbit_err) begin
                    check_value("rd_result.data", 32'(exp_result.data), 32'(rd_result.data));
                end
                check_value("rd_result.sbit_err", 32'(exp_result.sbit_err),
                            32'(rd_result.sbit_err));
                check_value("rd_result.dbit_err", 32'(exp_result.dbit_err),
                            32'(rd_result.dbit_err));
            end
            check_value("sbit_cnt", 32'(exp_sbit_cnt), 32'(sbit_cnt));
            check_value("dbit_cnt", 32'(exp_dbit_cnt), 32'(dbit_cnt));
        end
    end

endmodule

/* ecc_pkg.sv */
package ecc_pkg;

    // Word geometry.
    localparam int DATA_W    = 22;
    localparam int PAR_W     = 6;
    localparam int ADDR_W    = 5;
    localparam int MEM_DEPTH = 1 << ADDR_W;
    localparam int CNT_W     = 8;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [PAR_W-1:0]  parity_t;
    typedef logic [PAR_W-1:0]  syndrome_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [CNT_W-1:0]  err_cnt_t;

    // One stored word, check bits in the upper part.
    typedef struct packed {
        parity_t parity;
        data_t   data;
    } codeword_t;

    // Corrected read data with its error flags.
    typedef struct packed {
        data_t data;
        logic  sbit_err;
        logic  dbit_err;
    } rd_result_t;

endpackage

/* ecc_storage.sv */
`timescale 1ns/1ps

module ecc_storage import ecc_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      wr_en,
    input  addr_t     wr_addr,
    input  codeword_t wr_word,
    input  codeword_t wr_flip,
    input  logic      rd_en,
    input  addr_t     rd_addr,
    input  logic      bypass,
    output logic      rd_valid,
    output logic      rd_bypass,
    output codeword_t rd_word
);

    codeword_t mem [MEM_DEPTH];

    // Flip mask lets a test plant faults in the stored word.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word ^ wr_flip;
        end
    end

    // Read-first, a same-edge write is seen by the next read.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid  <= 1'b0;
            rd_bypass <= 1'b0;
        end else begin
            rd_valid <= rd_en;
            if (rd_en) begin
                rd_bypass <= bypass;
            end
        end
    end

endmodule

/* tb_ecc_mem.sv */
`timescale 1ns/1ps

module tb_ecc_mem import ecc_pkg::*; ();

    localparam int MIX_CYCLES  = 160;
    localparam int BYP_CYCLES  = 48;
    localparam int SAT_READS   = 520;
    localparam int STIM_CYCLES = 3 + 2 * MEM_DEPTH + MIX_CYCLES + 3 + BYP_CYCLES + SAT_READS + 12;
    localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES;

    logic       clk;
    logic       arst_n;
    logic       wr_en;
    addr_t      wr_addr;
    data_t      wr_data;
    codeword_t  wr_flip;
    logic       rd_en;
    addr_t      rd_addr;
    logic       bypass;
    logic       cnt_clr;
    logic       rd_valid;
    rd_result_t rd_result;
    err_cnt_t   sbit_cnt;
    err_cnt_t   dbit_cnt;
    int         error_count;
    int         read_count;
    logic [31:0] seed = 32'h94d7;
    int         cycles = 0;

    ecc_mem_top u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_flip   (wr_flip),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .bypass    (bypass),
        .cnt_clr   (cnt_clr),
        .rd_valid  (rd_valid),
        .rd_result (rd_result),
        .sbit_cnt  (sbit_cnt),
        .dbit_cnt  (dbit_cnt)
    );

    ecc_monitor u_monitor (
        .clk         (clk),
        .arst_n      (arst_n),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_flip     (wr_flip),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .bypass      (bypass),
        .cnt_clr     (cnt_clr),
        .rd_valid    (rd_valid),
        .rd_result   (rd_result),
        .sbit_cnt    (sbit_cnt),
        .dbit_cnt    (dbit_cnt),
        .error_count (error_count),
        .read_count  (read_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int rand_below(input int n);
        return int'((next_rand() >> 8) % n);
    endfunction

    function automatic data_t rand_data();
        return data_t'(next_rand() >> 6);
    endfunction

    function automatic addr_t rand_addr();
        return addr_t'(next_rand() >> 13);
    endfunction

    // Zero, one or two distinct bit positions across the whole codeword.
    function automatic codeword_t make_flip(input int n);
        codeword_t f;
        int        p1;
        int        p2;
        f  = '0;
        p1 = rand_below(DATA_W + PAR_W);
        p2 = (p1 + 1 + rand_below(DATA_W + PAR_W - 1)) % (DATA_W + PAR_W);
        if (n >= 1) begin
            f[p1] = 1'b1;
        end
        if (n == 2) begin
            f[p2] = 1'b1;
        end
        return f;
    endfunction

    task automatic step(input logic we, input addr_t wa, input data_t wd, input codeword_t wf,
                        input logic re, input addr_t ra, input logic byp, input logic clr);
        @(negedge clk);
        wr_en   = we;
        wr_addr = wa;
        wr_data = wd;
        wr_flip = wf;
        rd_en   = re;
        rd_addr = ra;
        bypass  = byp;
        cnt_clr = clr;
    endtask

    task automatic idle();
        step(1'b0, '0, '0, '0, 1'b0, '0, 1'b0, 1'b0);
    endtask

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("test failed");
        $finish;
    end

    initial begin
        int          i;
        logic [31:0] r;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        wr_flip = '0;
        rd_en   = 1'b0;
        rd_addr = '0;
        bypass  = 1'b0;
        cnt_clr = 1'b0;
        arst_n  = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // Clean fill, then read every word back.
        for (i = 0; i < MEM_DEPTH; i++) begin
            step(1'b1, addr_t'(i), rand_data(), '0, 1'b0, '0, 1'b0, 1'b0);
        end
        for (i = 0; i < MEM_DEPTH; i++) begin
            step(1'b0, '0, '0, '0, 1'b1, addr_t'(i), 1'b0, 1'b0);
        end

        // Random traffic with 0, 1 or 2 planted faults.
        for (i = 0; i < MIX_CYCLES; i++) begin
            r = next_rand();
            step(r[9], rand_addr(), rand_data(), make_flip(rand_below(3)), r[13], rand_addr(),
                 1'b0, r[21:17] == 5'd0);
        end

        // Same-edge read and write, then read the new word.
        step(1'b1, 5'd7, 22'h2a5f31, '0, 1'b0, '0, 1'b0, 1'b0);
        step(1'b1, 5'd7, 22'h15a0ce, '0, 1'b1, 5'd7, 1'b0, 1'b0);
        step(1'b0, '0, '0, '0, 1'b1, 5'd7, 1'b0, 1'b0);

        for (i = 0; i < BYP_CYCLES; i++) begin
            r = next_rand();
            step(r[5], rand_addr(), rand_data(), make_flip(rand_below(3)), 1'b1, rand_addr(),
                 1'b1, 1'b0);
        end

        // Push both counters into saturation.
        step(1'b1, 5'd0, rand_data(), make_flip(1), 1'b0, '0, 1'b0, 1'b1);
        step(1'b1, 5'd1, rand_data(), make_flip(2), 1'b0, '0, 1'b0, 1'b0);
        for (i = 0; i < SAT_READS; i++) begin
            step(1'b0, '0, '0, '0, 1'b1, addr_t'(i % 2), 1'b0, 1'b0);
        end

        // Clear lands on a flagged result cycle.
        step(1'b0, '0, '0, '0, 1'b1, 5'd0, 1'b0, 1'b0);
        step(1'b0, '0, '0, '0, 1'b0, '0, 1'b0, 1'b1);
        step(1'b0, '0, '0, '0, 1'b1, 5'd0, 1'b0, 1'b0);
        step(1'b0, '0, '0, '0, 1'b1, 5'd1, 1'b0, 1'b0);
        repeat (4) idle();
        @(posedge clk);

        $display("reads checked %0d, errors %0d", read_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
